//--- source/udp_demux_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP demultiplexer shared definitions
// header field widths and types, and the frame tracking state
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package udp_demux_pkg;

    // ipv4 address
    localparam int IP_ADDR_W = 32;

    // udp ports, length and checksum all share one width
    localparam int UDP_FIELD_W = 16;

    typedef logic [IP_ADDR_W-1:0] ip_addr_t;

    typedef logic [UDP_FIELD_W-1:0] udp_field_t;

    // idle waits for a header, active passes payload until last
    typedef enum logic [0:0] {
        FRAME_IDLE   = 1'b0,
        FRAME_ACTIVE = 1'b1
    } frame_state_t;

endpackage

//--- source/demux_frame_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP demux frame control
// tracks frame boundaries, latches the output port at frame start
// and drives the header and payload input readies
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module demux_frame_ctrl
    import udp_demux_pkg::*;
#(
    parameter int NUM_PORTS = 4,
    localparam int SEL_W = $clog2(NUM_PORTS)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    input  logic [SEL_W-1:0] select,
    input  logic             in_hdr_valid,
    input  logic             in_tvalid,
    input  logic             in_tlast,
    input  logic             hdr_busy,
    input  logic             payload_busy,
    input  logic             ready_early,
    output logic             in_hdr_ready,
    output logic             in_tready,
    output logic             frame_start,
    output logic [SEL_W-1:0] start_port,
    output logic [SEL_W-1:0] port_sel
);

    frame_state_t     state;
    frame_state_t     state_next;
    logic [SEL_W-1:0] port_reg;
    logic             hdr_ready_reg;
    logic             tready_reg;
    logic             start;

    // new frame only once the previous port has drained its header and payload
    assign start = (state == FRAME_IDLE) && enable && in_hdr_valid
                   && !hdr_busy && !payload_busy;

    always_comb begin
        state_next = state;
        case (state)
            FRAME_IDLE: begin
                if (start) begin
                    state_next = FRAME_ACTIVE;
                end
            end
            FRAME_ACTIVE: begin
                // accepted last word closes the frame
                if (in_tvalid && tready_reg && in_tlast) begin
                    state_next = FRAME_IDLE;
                end
            end
            default: begin
                state_next = FRAME_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= FRAME_IDLE;
            port_reg      <= '0;
            hdr_ready_reg <= 1'b0;
            tready_reg    <= 1'b0;
        end else begin
            state         <= state_next;
            // header ready is a single cycle pulse after the start edge
            hdr_ready_reg <= start;
            tready_reg    <= ready_early && (state_next == FRAME_ACTIVE);
            if (start) begin
                port_reg <= select;
            end
        end
    end

    assign in_hdr_ready = hdr_ready_reg;
    assign in_tready    = tready_reg;
    assign frame_start  = start;
    assign start_port   = select;
    assign port_sel     = port_reg;

endmodule

//--- source/demux_hdr_capture.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP demux header capture
// registers the header fields at frame start and raises the header
// valid of the chosen port until that port accepts it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module demux_hdr_capture
    import udp_demux_pkg::*;
#(
    parameter int NUM_PORTS = 4,
    localparam int SEL_W = $clog2(NUM_PORTS)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 frame_start,
    input  logic [SEL_W-1:0]     start_port,
    input  logic [SEL_W-1:0]     port_sel,
    input  logic [NUM_PORTS-1:0] out_hdr_ready,
    input  ip_addr_t             in_ip_source_ip,
    input  ip_addr_t             in_ip_dest_ip,
    input  udp_field_t           in_udp_source_port,
    input  udp_field_t           in_udp_dest_port,
    input  udp_field_t           in_udp_length,
    input  udp_field_t           in_udp_checksum,
    output ip_addr_t             out_ip_source_ip,
    output ip_addr_t             out_ip_dest_ip,
    output udp_field_t           out_udp_source_port,
    output udp_field_t           out_udp_dest_port,
    output udp_field_t           out_udp_length,
    output udp_field_t           out_udp_checksum,
    output logic [NUM_PORTS-1:0] out_hdr_valid,
    output logic                 hdr_busy
);

    // field registers are shared by every port
    always_ff @(posedge clk) begin
        if (frame_start) begin
            out_ip_source_ip    <= in_ip_source_ip;
            out_ip_dest_ip      <= in_ip_dest_ip;
            out_udp_source_port <= in_udp_source_port;
            out_udp_dest_port   <= in_udp_dest_port;
            out_udp_length      <= in_udp_length;
            out_udp_checksum    <= in_udp_checksum;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_hdr_valid <= '0;
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (frame_start && (start_port == SEL_W'(i))) begin
                    out_hdr_valid[i] <= 1'b1;
                end else if (out_hdr_ready[i]) begin
                    // each port clears on its own handshake
                    out_hdr_valid[i] <= 1'b0;
                end
            end
        end
    end

    // header still pending on the port of the current frame
    assign hdr_busy = out_hdr_valid[port_sel];

endmodule

//--- source/demux_payload_skid.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP demux payload skid stage
// registered payload output with one spare slot, steered to the
// latched port, and the early ready for the input side
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module demux_payload_skid #(
    parameter int DATA_WIDTH = 64,
    parameter int NUM_PORTS = 4,
    localparam int KEEP_W = DATA_WIDTH / 8,
    localparam int SEL_W = $clog2(NUM_PORTS)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [SEL_W-1:0]      port_sel,
    input  logic [DATA_WIDTH-1:0] in_tdata,
    input  logic [KEEP_W-1:0]     in_tkeep,
    input  logic                  in_tlast,
    input  logic                  in_tuser,
    input  logic                  beat_valid,
    input  logic [NUM_PORTS-1:0]  out_tready,
    output logic [DATA_WIDTH-1:0] out_tdata,
    output logic [KEEP_W-1:0]     out_tkeep,
    output logic                  out_tlast,
    output logic                  out_tuser,
    output logic [NUM_PORTS-1:0]  out_tvalid,
    output logic                  payload_busy,
    output logic                  ready_early
);

    logic [DATA_WIDTH-1:0] spare_tdata;
    logic [KEEP_W-1:0]     spare_tkeep;
    logic                  spare_tlast;
    logic                  spare_tuser;
    logic                  spare_valid;
    logic                  cur_valid;
    logic                  cur_ready;
    logic                  load_out;

    assign cur_valid = out_tvalid[port_sel];
    assign cur_ready = out_tready[port_sel];

    // incoming word goes straight out when the output slot frees up this edge
    assign load_out = cur_ready || !cur_valid;

    // accept next cycle unless the spare would be full by then
    assign ready_early = cur_ready || (!spare_valid && (!cur_valid || !beat_valid));

    assign payload_busy = cur_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_tvalid  <= '0;
            spare_valid <= 1'b0;
        end else if (beat_valid) begin
            if (load_out) begin
                out_tvalid[port_sel] <= 1'b1;
            end else begin
                spare_valid <= 1'b1;
            end
        end else if (cur_ready) begin
            // sink drained, refill from the spare or go empty
            out_tvalid[port_sel] <= spare_valid;
            spare_valid          <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            if (load_out) begin
                out_tdata <= in_tdata;
                out_tkeep <= in_tkeep;
                out_tlast <= in_tlast;
                out_tuser <= in_tuser;
            end else begin
                spare_tdata <= in_tdata;
                spare_tkeep <= in_tkeep;
                spare_tlast <= in_tlast;
                spare_tuser <= in_tuser;
            end
        end else if (cur_ready && spare_valid) begin
            out_tdata <= spare_tdata;
            out_tkeep <= spare_tkeep;
            out_tlast <= spare_tlast;
            out_tuser <= spare_tuser;
        end
    end

endmodule

//--- source/udp_demux_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP frame demultiplexer, one input to NUM_PORTS outputs
// steers header and payload of each frame to the port latched at start
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module udp_demux_top
    import udp_demux_pkg::*;
#(
    parameter int DATA_WIDTH = 64,
    parameter int NUM_PORTS = 4,
    localparam int KEEP_W = DATA_WIDTH / 8,
    localparam int SEL_W = $clog2(NUM_PORTS)
) (
    input  logic                  clk,
    input  logic                  rst,
    // header input
    input  logic                  in_hdr_valid,
    output logic                  in_hdr_ready,
    input  ip_addr_t              in_ip_source_ip,
    input  ip_addr_t              in_ip_dest_ip,
    input  udp_field_t            in_udp_source_port,
    input  udp_field_t            in_udp_dest_port,
    input  udp_field_t            in_udp_length,
    input  udp_field_t            in_udp_checksum,
    // payload input
    input  logic [DATA_WIDTH-1:0] in_tdata,
    input  logic [KEEP_W-1:0]     in_tkeep,
    input  logic                  in_tvalid,
    output logic                  in_tready,
    input  logic                  in_tlast,
    input  logic                  in_tuser,
    // header outputs, valid and ready per port
    output logic [NUM_PORTS-1:0]  out_hdr_valid,
    input  logic [NUM_PORTS-1:0]  out_hdr_ready,
    output ip_addr_t              out_ip_source_ip,
    output ip_addr_t              out_ip_dest_ip,
    output udp_field_t            out_udp_source_port,
    output udp_field_t            out_udp_dest_port,
    output udp_field_t            out_udp_length,
    output udp_field_t            out_udp_checksum,
    // payload outputs
    output logic [DATA_WIDTH-1:0] out_tdata,
    output logic [KEEP_W-1:0]     out_tkeep,
    output logic [NUM_PORTS-1:0]  out_tvalid,
    input  logic [NUM_PORTS-1:0]  out_tready,
    output logic                  out_tlast,
    output logic                  out_tuser,
    // control
    input  logic                  enable,
    input  logic [SEL_W-1:0]      select
);

    logic             frame_start;
    logic [SEL_W-1:0] start_port;
    logic [SEL_W-1:0] port_sel;
    logic             hdr_busy;
    logic             payload_busy;
    logic             ready_early;
    logic             beat_valid;

    // word transferred on the input this cycle
    assign beat_valid = in_tvalid && in_tready;

    demux_frame_ctrl #(
        .NUM_PORTS(NUM_PORTS)
    ) demux_frame_ctrl_inst (
        .clk(clk),
        .rst(rst),
        .enable(enable),
        .select(select),
        .in_hdr_valid(in_hdr_valid),
        .in_tvalid(in_tvalid),
        .in_tlast(in_tlast),
        .hdr_busy(hdr_busy),
        .payload_busy(payload_busy),
        .ready_early(ready_early),
        .in_hdr_ready(in_hdr_ready),
        .in_tready(in_tready),
        .frame_start(frame_start),
        .start_port(start_port),
        .port_sel(port_sel)
    );

    demux_hdr_capture #(
        .NUM_PORTS(NUM_PORTS)
    ) demux_hdr_capture_inst (
        .clk(clk),
        .rst(rst),
        .frame_start(frame_start),
        .start_port(start_port),
        .port_sel(port_sel),
        .out_hdr_ready(out_hdr_ready),
        .in_ip_source_ip(in_ip_source_ip),
        .in_ip_dest_ip(in_ip_dest_ip),
        .in_udp_source_port(in_udp_source_port),
        .in_udp_dest_port(in_udp_dest_port),
        .in_udp_length(in_udp_length),
        .in_udp_checksum(in_udp_checksum),
        .out_ip_source_ip(out_ip_source_ip),
        .out_ip_dest_ip(out_ip_dest_ip),
        .out_udp_source_port(out_udp_source_port),
        .out_udp_dest_port(out_udp_dest_port),
        .out_udp_length(out_udp_length),
        .out_udp_checksum(out_udp_checksum),
        .out_hdr_valid(out_hdr_valid),
        .hdr_busy(hdr_busy)
    );

    demux_payload_skid #(
        .DATA_WIDTH(DATA_WIDTH),
        .NUM_PORTS(NUM_PORTS)
    ) demux_payload_skid_inst (
        .clk(clk),
        .rst(rst),
        .port_sel(port_sel),
        .in_tdata(in_tdata),
        .in_tkeep(in_tkeep),
        .in_tlast(in_tlast),
        .in_tuser(in_tuser),
        .beat_valid(beat_valid),
        .out_tready(out_tready),
        .out_tdata(out_tdata),
        .out_tkeep(out_tkeep),
        .out_tlast(out_tlast),
        .out_tuser(out_tuser),
        .out_tvalid(out_tvalid),
        .payload_busy(payload_busy),
        .ready_early(ready_early)
    );

endmodule

//--- sim/udp_demux_tb_frames.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP demux frame table
// columns: port, enable gap, six header fields, beat count,
// keep of the last word, user flag, sink stall mode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int NUM_FRAMES = 6;

    typedef struct packed {
        logic [1:0] sel;
        logic [3:0] gap;
        ip_addr_t   src_ip;
        ip_addr_t   dst_ip;
        udp_field_t src_port;
        udp_field_t dst_port;
        udp_field_t length;
        udp_field_t checksum;
        logic [7:0] beats;
        logic [7:0] last_keep;
        logic       user;
        logic       stall;
    } frame_row_t;

    function automatic frame_row_t frame_row(input int idx);
        frame_row_t row;
        case (idx)
            0: row = '{2'd0, 4'd0, 32'hc0a8_0001, 32'h0a00_0001, 16'd1024, 16'd80,
                       16'd32, 16'h1a2b, 8'd3, 8'hff, 1'b0, 1'b0};
            1: row = '{2'd1, 4'd3, 32'hc0a8_0002, 32'h0a00_0002, 16'd5000, 16'd53,
                       16'd48, 16'h2c3d, 8'd5, 8'h0f, 1'b1, 1'b1};
            2: row = '{2'd2, 4'd0, 32'hc0a8_0003, 32'h0a00_0003, 16'd6001, 16'd123,
                       16'd16, 16'h3e4f, 8'd1, 8'h01, 1'b1, 1'b0};
            3: row = '{2'd3, 4'd2, 32'hc0a8_0004, 32'h0a00_0004, 16'd7002, 16'd4789,
                       16'd72, 16'h4051, 8'd8, 8'h3f, 1'b0, 1'b1};
            4: row = '{2'd2, 4'd0, 32'hc0a8_0005, 32'h0a00_0005, 16'd8003, 16'd67,
                       16'd56, 16'h5263, 8'd6, 8'h7f, 1'b0, 1'b1};
            5: row = '{2'd0, 4'd4, 32'hc0a8_0006, 32'h0a00_0006, 16'd9004, 16'd161,
                       16'd40, 16'h6475, 8'd4, 8'hff, 1'b1, 1'b1};
            default: row = '0;
        endcase
        return row;
    endfunction

//--- sim/udp_demux_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP demux testbench
// applies the frame table and checks header and payload routing per port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module udp_demux_tb
    import udp_demux_pkg::*;
();

    localparam int DATA_WIDTH = 64;
    localparam int NUM_PORTS = 4;
    localparam int KEEP_W = DATA_WIDTH / 8;
    localparam int CLK_PERIOD = 40;

    `include "udp_demux_tb_frames.svh"

    // expected payload word with the port it must leave on
    typedef struct packed {
        logic [1:0]            port;
        logic                  last;
        logic                  user;
        logic [KEEP_W-1:0]     keep;
        logic [DATA_WIDTH-1:0] data;
    } word_t;

    logic                  clk;
    logic                  rst;
    logic                  enable;
    logic [1:0]            select;
    logic                  in_hdr_valid;
    logic                  in_hdr_ready;
    ip_addr_t              in_ip_source_ip;
    ip_addr_t              in_ip_dest_ip;
    udp_field_t            in_udp_source_port;
    udp_field_t            in_udp_dest_port;
    udp_field_t            in_udp_length;
    udp_field_t            in_udp_checksum;
    logic [DATA_WIDTH-1:0] in_tdata;
    logic [KEEP_W-1:0]     in_tkeep;
    logic                  in_tvalid;
    logic                  in_tready;
    logic                  in_tlast;
    logic                  in_tuser;
    logic [NUM_PORTS-1:0]  out_hdr_valid;
    logic [NUM_PORTS-1:0]  out_hdr_ready;
    ip_addr_t              out_ip_source_ip;
    ip_addr_t              out_ip_dest_ip;
    udp_field_t            out_udp_source_port;
    udp_field_t            out_udp_dest_port;
    udp_field_t            out_udp_length;
    udp_field_t            out_udp_checksum;
    logic [DATA_WIDTH-1:0] out_tdata;
    logic [KEEP_W-1:0]     out_tkeep;
    logic [NUM_PORTS-1:0]  out_tvalid;
    logic [NUM_PORTS-1:0]  out_tready;
    logic                  out_tlast;
    logic                  out_tuser;

    frame_row_t exp_hdr_q[$];
    word_t      exp_word_q[$];
    int         exp_beats_q[$];
    int         error_count = 0;
    int         hdr_count = 0;
    int         word_count = 0;
    int         beat_count = 0;
    integer     seed = 9;
    logic       stall_mode = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    udp_demux_top #(
        .DATA_WIDTH(DATA_WIDTH),
        .NUM_PORTS(NUM_PORTS)
    ) udp_demux_top_inst (.*);

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        error_count++;
    endtask

    // word k of frame f, keep and user only differ on the last word
    function automatic word_t make_word(input frame_row_t row, input int f, input int k);
        word_t w;
        w.port = row.sel;
        w.data = {8'(f), 8'(k), 16'h5a5a, 16'(f * 977 + k * 31), 16'(~k)};
        w.last = (k == row.beats - 1);
        w.keep = w.last ? row.last_keep : '1;
        w.user = w.last && row.user;
        return w;
    endfunction

    task automatic apply_frame(input int f);
        frame_row_t           row;
        word_t                w;
        logic [NUM_PORTS-1:0] hdr_prev;
        int                   k;
        row = frame_row(f);
        stall_mode <= row.stall;
        exp_hdr_q.push_back(row);
        exp_beats_q.push_back(row.beats);
        for (k = 0; k < row.beats; k++) begin
            exp_word_q.push_back(make_word(row, f, k));
        end
        select = row.sel;
        {in_ip_source_ip, in_ip_dest_ip, in_udp_source_port, in_udp_dest_port,
         in_udp_length, in_udp_checksum} = {row.src_ip, row.dst_ip, row.src_port,
                                            row.dst_port, row.length, row.checksum};
        in_hdr_valid = 1'b1;
        enable = (row.gap == 0);
        hdr_prev = out_hdr_valid;
        repeat (row.gap) begin
            @(negedge clk);
            if (in_hdr_ready !== 1'b0) report_error("header accepted while enable was low");
            if ((out_hdr_valid & ~hdr_prev) != '0) report_error("header valid rose while disabled");
            hdr_prev = out_hdr_valid;
        end
        enable = 1'b1;
        while (in_hdr_ready !== 1'b1) @(negedge clk);
        @(negedge clk);
        in_hdr_valid = 1'b0;
        if (in_hdr_ready !== 1'b0) report_mismatch("in_hdr_ready", 0, in_hdr_ready);
        // a word moves on the next rising edge whenever in_tready is high now
        k = 0;
        while (k < row.beats) begin
            w = make_word(row, f, k);
            in_tdata = w.data;
            in_tkeep = w.keep;
            in_tlast = w.last;
            in_tuser = w.user;
            in_tvalid = 1'b1;
            if (in_tready === 1'b1) k++;
            @(negedge clk);
        end
        in_tvalid = 1'b0;
    endtask

    // sinks for every port, transfers are seen at the edge after this one
    always @(negedge clk) begin : sinks
        logic [NUM_PORTS-1:0] rdy;
        logic [NUM_PORTS-1:0] hrdy;
        frame_row_t           hrow;
        word_t                w;
        rdy = stall_mode ? NUM_PORTS'($random(seed)) : '1;
        hrdy = stall_mode ? NUM_PORTS'($random(seed)) : '1;
        out_tready = rdy;
        out_hdr_ready = hrdy;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (out_hdr_valid[p] && exp_hdr_q.size() == 0) begin
                report_error("header valid raised with no frame pending");
            end else if (out_hdr_valid[p]) begin
                hrow = exp_hdr_q[0];
                if (p != hrow.sel) report_mismatch("out_hdr_valid port", hrow.sel, p);
                if (hrdy[p] && p == hrow.sel) begin
                    if ({out_ip_source_ip, out_ip_dest_ip, out_udp_source_port,
                         out_udp_dest_port, out_udp_length, out_udp_checksum} !==
                        {hrow.src_ip, hrow.dst_ip, hrow.src_port, hrow.dst_port,
                         hrow.length, hrow.checksum}) begin
                        report_mismatch("out header fields",
                                        {hrow.src_ip, hrow.dst_ip, hrow.src_port,
                                         hrow.dst_port, hrow.length, hrow.checksum},
                                        {out_ip_source_ip, out_ip_dest_ip, out_udp_source_port,
                                         out_udp_dest_port, out_udp_length, out_udp_checksum});
                    end
                    void'(exp_hdr_q.pop_front());
                    hdr_count++;
                end
            end
            if (out_tvalid[p] && rdy[p]) begin
                if (exp_word_q.size() == 0) begin
                    report_error("payload word received beyond the last expected word");
                end else begin
                    w = exp_word_q.pop_front();
                    if (p != w.port) report_mismatch("out_tvalid port", w.port, p);
                    if (out_tdata !== w.data) report_mismatch("out_tdata", w.data, out_tdata);
                    if (out_tkeep !== w.keep) report_mismatch("out_tkeep", w.keep, out_tkeep);
                    if (out_tlast !== w.last) report_mismatch("out_tlast", w.last, out_tlast);
                    if (out_tuser !== w.user) report_mismatch("out_tuser", w.user, out_tuser);
                    word_count++;
                end
                beat_count++;
                if (out_tlast === 1'b1 && exp_beats_q.size() != 0) begin
                    if (beat_count != exp_beats_q[0]) begin
                        report_mismatch("words per frame", exp_beats_q[0], beat_count);
                    end
                    void'(exp_beats_q.pop_front());
                    beat_count = 0;
                end
            end
        end
    end

    initial begin : stimulus
        clk = 1'b0;
        rst = 1'b1;
        enable = 1'b1;
        select = '0;
        in_hdr_valid = 1'b0;
        {in_ip_source_ip, in_ip_dest_ip, in_udp_source_port, in_udp_dest_port,
         in_udp_length, in_udp_checksum} = '0;
        in_tdata = '0;
        in_tkeep = '0;
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        in_tuser = 1'b0;
        out_hdr_ready = '0;
        out_tready = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (in_hdr_ready !== 1'b0) report_mismatch("in_hdr_ready", 0, in_hdr_ready);
        if (in_tready !== 1'b0) report_mismatch("in_tready", 0, in_tready);
        if (out_hdr_valid !== '0) report_mismatch("out_hdr_valid", 0, out_hdr_valid);
        if (out_tvalid !== '0) report_mismatch("out_tvalid", 0, out_tvalid);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            apply_frame(f);
        end
        while (exp_word_q.size() != 0 || exp_hdr_q.size() != 0) @(posedge clk);
        repeat (3) @(negedge clk);
        if (out_tvalid !== '0) report_mismatch("out_tvalid", 0, out_tvalid);
        if (out_hdr_valid !== '0) report_mismatch("out_hdr_valid", 0, out_hdr_valid);
        $display("frames %0d, headers %0d, words %0d, errors %0d",
                 NUM_FRAMES, hdr_count, word_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // limit grows with the number of payload words in the table
    initial begin : watchdog
        frame_row_t row;
        int         limit;
        limit = 200;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            row = frame_row(f);
            limit += 40 * row.beats;
        end
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the frames did not finish", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+sim
source/udp_demux_pkg.sv
source/demux_frame_ctrl.sv
source/demux_hdr_capture.sv
source/demux_payload_skid.sv
source/udp_demux_top.sv
sim/udp_demux_tb.sv
